// File: sim.f
+incdir+common
common/memSysPkg.sv
rtl/busMemory.sv
rtl/busArbiter.sv
rtl/dataPort.sv
instrCache/instrCache.sv
rtl/memSystem.sv
bench/clockGen.sv
bench/memChecker.sv
bench/memSystemTb.sv

// File: bench/memSystemTb.sv
// Testbench that plays the core, issuing fetches, loads and stores to the memory system
`timescale 1ns/1ps

module memSystemTb;

  // Worst case of about 300 transfers at 12 cycles, plus margin
  localparam int Transfers      = 300;
  localparam int TransferCycles = 12;
  localparam int MaxCycles      = Transfers * TransferCycles + 400;
  localparam int DriveDelay     = 1;
  localparam int TestWords      = 24;

  logic                clk;
  logic                reset;
  memSysPkg::addrT     pc;
  logic                icEnable;
  logic                icInvalidate;
  memSysPkg::wordT     instr;
  logic                iStall;
  memSysPkg::addrT     dataAddr;
  memSysPkg::wordT     writeData;
  logic                memRead;
  logic                memWrite;
  memSysPkg::byteMaskT byteMask;
  memSysPkg::wordT     readData;
  logic                dStall;
  logic                fetchCheck;

  int          errors;
  int          checks;
  int          cycles    = 0;
  int          passCount = 0;
  int          failCount = 0;
  // Latency failures seen by the stimulus side
  int          tbErrors  = 0;
  int          errMark;
  int          checkMark;
  int          tbMark;
  logic [31:0] lfsrState = 32'he91a;
  logic [7:0]  testWord [TestWords];

  // Byte, halfword and word lane patterns
  memSysPkg::byteMaskT maskTable [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                         4'b0011, 4'b1100, 4'b1111, 4'b0011};

  clockGen clockGen0 (
    .clk  (clk  ),
    .reset(reset)
  );

  memSystem dut0 (
    .clk         (clk         ),
    .reset       (reset       ),
    .pc          (pc          ),
    .icEnable    (icEnable    ),
    .icInvalidate(icInvalidate),
    .instr       (instr       ),
    .iStall      (iStall      ),
    .dataAddr    (dataAddr    ),
    .writeData   (writeData   ),
    .memRead     (memRead     ),
    .memWrite    (memWrite    ),
    .byteMask    (byteMask    ),
    .readData    (readData    ),
    .dStall      (dStall      )
  );

  memChecker check0 (
    .clk         (clk         ),
    .reset       (reset       ),
    .pc          (pc          ),
    .icEnable    (icEnable    ),
    .icInvalidate(icInvalidate),
    .instr       (instr       ),
    .iStall      (iStall      ),
    .fetchCheck  (fetchCheck  ),
    .dataAddr    (dataAddr    ),
    .writeData   (writeData   ),
    .memRead     (memRead     ),
    .memWrite    (memWrite    ),
    .byteMask    (byteMask    ),
    .readData    (readData    ),
    .dStall      (dStall      ),
    .errors      (errors      ),
    .checks      (checks      )
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit
  task automatic takeBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
  endtask

  // Load or store held until dStall falls
  task automatic dataAccess(input logic isWrite, input logic [7:0] word,
                            input memSysPkg::byteMaskT mask, input memSysPkg::wordT data);
    @(posedge clk);
    #DriveDelay;
    dataAddr  = {22'd0, word, 2'b00};
    writeData = data;
    byteMask  = mask;
    memRead   = !isWrite;
    memWrite  = isWrite;
    @(negedge clk);
    while (dStall)
      @(negedge clk);
    @(posedge clk);
    #DriveDelay;
    memRead  = 1'b0;
    memWrite = 1'b0;
  endtask

  // Let a bus fetch in flight finish before pc moves
  task automatic fetchSync();
    @(negedge clk);
    while (iStall)
      @(negedge clk);
    @(posedge clk);
    #DriveDelay;
  endtask

  task automatic fetch(input logic [7:0] word, output int stallCycles);
    fetchSync();
    pc          = {22'd0, word, 2'b00};
    fetchCheck  = 1'b1;
    stallCycles = 0;
    @(negedge clk);
    while (iStall)
    begin
      stallCycles++;
      @(negedge clk);
    end
    @(posedge clk);
    #DriveDelay;
    fetchCheck = 1'b0;
  endtask

  // Cache on, all lines dropped, pc parked on a line base
  task automatic flushCache(input logic [7:0] word);
    fetchSync();
    pc           = {22'd0, word, 2'b00};
    icEnable     = 1'b1;
    icInvalidate = 1'b1;
    @(posedge clk);
    #DriveDelay;
    icInvalidate = 1'b0;
  endtask

  task automatic expectHit(input int stallCycles);
    if (stallCycles != 0)
    begin
      $display("Fetch at pc %h stalled %0d cycles on what should be a cache hit",
               pc, stallCycles);
      tbErrors++;
    end
  endtask

  task automatic startTest();
    errMark   = errors;
    checkMark = checks;
    tbMark    = tbErrors;
  endtask

  task automatic finishTest(input string name);
    if (checks == checkMark)
    begin
      $display("%s: failed, nothing was checked", name);
      failCount++;
    end
    else if (errors != errMark || tbErrors != tbMark)
    begin
      $display("%s: failed with %0d errors", name, errors - errMark + tbErrors - tbMark);
      failCount++;
    end
    else
    begin
      $display("%s: passed, %0d checks", name, checks - checkMark);
      passCount++;
    end
  endtask

  // Run limit
  initial
  begin
    while (cycles < MaxCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles, a stall never ended", cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin : stimulus
    logic [31:0] bits;
    logic [7:0]  lineWord;
    int          stalls;
    pc           = '0;
    icEnable     = 1'b0;
    icInvalidate = 1'b0;
    dataAddr     = '0;
    writeData    = '0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    byteMask     = 4'b1111;
    fetchCheck   = 1'b0;
    // Reset is already high at the first rising edge
    @(posedge clk);
    while (reset)
      @(posedge clk);

    // 1: full words, fetch side bypassing in the background
    startTest();
    for (int i = 0; i < TestWords; i++)
    begin
      takeBits(8, bits);
      testWord[i] = bits[7:0];
      takeBits(32, bits);
      dataAccess(1'b1, testWord[i], 4'b1111, bits);
    end
    for (int i = 0; i < TestWords; i++)
      dataAccess(1'b0, testWord[i], 4'b1111, '0);
    finishTest("Test 1 word write and read");

    // 2: sub-word stores, full and sub-word loads
    startTest();
    for (int i = 0; i < 16; i++)
    begin
      takeBits(3, bits);
      byteMask = maskTable[bits[2:0]];
      takeBits(32, bits);
      dataAccess(1'b1, testWord[i], byteMask, bits);
      dataAccess(1'b0, testWord[i], 4'b1111, '0);
      takeBits(3, bits);
      dataAccess(1'b0, testWord[i], maskTable[bits[2:0]], '0);
    end
    finishTest("Test 2 byte and halfword lanes");

    // 3: cache disabled
    startTest();
    for (int i = 0; i < 8; i++)
      fetch(testWord[i], stalls);
    finishTest("Test 3 bypass fetch");

    // 4: hits, stale line, then invalidate
    startTest();
    takeBits(6, bits);
    lineWord = {bits[5:0], 2'b00};
    for (int w = 0; w < 4; w++)
    begin
      takeBits(32, bits);
      dataAccess(1'b1, lineWord + 8'(w), 4'b1111, bits);
    end
    flushCache(lineWord);
    fetch(lineWord, stalls);
    for (int w = 1; w < 4; w++)
    begin
      fetch(lineWord + 8'(w), stalls);
      expectHit(stalls);
    end
    takeBits(32, bits);
    dataAccess(1'b1, lineWord + 8'd1, 4'b1111, bits);
    fetch(lineWord + 8'd1, stalls);
    expectHit(stalls);
    flushCache(lineWord + 8'd1);
    fetch(lineWord + 8'd1, stalls);
    finishTest("Test 4 cache hit and invalidate");

    // 5: data access during a refill of a conflicting line
    startTest();
    takeBits(32, bits);
    dataAccess(1'b1, lineWord ^ 8'h40, 4'b1111, bits);
    takeBits(32, bits);
    dataAccess(1'b1, (lineWord ^ 8'h40) + 8'd3, 4'b1111, bits);
    fork
      begin
        fetch(lineWord ^ 8'h40, stalls);
        fetch((lineWord ^ 8'h40) + 8'd3, stalls);
        expectHit(stalls);
      end
      begin
        repeat (3) @(posedge clk);
        takeBits(32, bits);
        dataAccess(1'b1, lineWord ^ 8'hc0, 4'b1111, bits);
        dataAccess(1'b0, lineWord ^ 8'hc0, 4'b1111, '0);
        dataAccess(1'b0, testWord[0], 4'b1111, '0);
      end
    join
    finishTest("Test 5 data during refill");

    $display("Tests passed: %0d, failed: %0d, mismatches: %0d, other errors: %0d",
             passCount, failCount, errors, tbErrors);
    if (failCount == 0 && errors == 0 && tbErrors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: bench/memChecker.sv
// Watcher with a shadow memory and cache line model that checks loads and fetches
`timescale 1ns/1ps
`include "memSystem_settings.svh"

module memChecker (
  input  logic                clk,
  input  logic                reset,
  input  memSysPkg::addrT     pc,
  input  logic                icEnable,
  input  logic                icInvalidate,
  input  memSysPkg::wordT     instr,
  input  logic                iStall,
  input  logic                fetchCheck,
  input  memSysPkg::addrT     dataAddr,
  input  memSysPkg::wordT     writeData,
  input  logic                memRead,
  input  logic                memWrite,
  input  memSysPkg::byteMaskT byteMask,
  input  memSysPkg::wordT     readData,
  input  logic                dStall,
  output int                  errors,
  output int                  checks
);

  // Memory image as the core wrote it
  memSysPkg::wordT shadow [`MEM_WORDS];

  // Lines the cache should hold, captured from the shadow on a miss
  logic            lineValid [`IC_LINES];
  int              lineTag   [`IC_LINES];
  memSysPkg::wordT lineData  [`IC_LINES][`IC_BLOCK_WORDS];

  int              errCount   = 0;
  int              checkCount = 0;
  memSysPkg::wordT expData;
  memSysPkg::wordT expInstr;

  assign errors = errCount;
  assign checks = checkCount;

  // Sub-word data sits at bit 0 on the core side
  function automatic int lowestLane(input memSysPkg::byteMaskT mask);
    for (int lane = 0; lane < 4; lane++)
    begin
      if (mask[lane])
        return lane;
    end
    return 0;
  endfunction

  // Expected load, enabled bytes moved down to bit 0 and zero-extended
  function automatic memSysPkg::wordT expectRead(input memSysPkg::addrT addr,
                                                 input memSysPkg::byteMaskT mask);
    memSysPkg::wordT word;
    memSysPkg::wordT result;
    int              low;
    word   = shadow[(addr >> 2) % `MEM_WORDS];
    low    = lowestLane(mask);
    result = '0;
    for (int lane = low; lane < 4; lane++)
    begin
      if (mask[lane])
        result[8*(lane-low) +: 8] = word[8*lane +: 8];
    end
    return result;
  endfunction

  // Store lands only in the enabled lanes
  task automatic storeWrite();
    int low;
    int word;
    low  = lowestLane(byteMask);
    word = (dataAddr >> 2) % `MEM_WORDS;
    for (int lane = low; lane < 4; lane++)
    begin
      if (byteMask[lane])
        shadow[word][8*lane +: 8] = writeData[8*(lane-low) +: 8];
    end
  endtask

  // Bypass reads memory, enabled fetch reads the modelled line
  task automatic expectFetch(input memSysPkg::addrT addr, output memSysPkg::wordT value);
    int word;
    int line;
    int tag;
    word = addr >> 2;
    line = (word / `IC_BLOCK_WORDS) % `IC_LINES;
    tag  = word / (`IC_BLOCK_WORDS * `IC_LINES);
    if (!icEnable)
      value = shadow[word % `MEM_WORDS];
    else
    begin
      // Miss pulls the whole line in
      if (!lineValid[line] || lineTag[line] != tag)
      begin
        for (int w = 0; w < `IC_BLOCK_WORDS; w++)
          lineData[line][w] = shadow[(word - word % `IC_BLOCK_WORDS + w) % `MEM_WORDS];
        lineValid[line] = 1'b1;
        lineTag[line]   = tag;
      end
      value = lineData[line][word % `IC_BLOCK_WORDS];
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk)
  begin
    if (reset || icInvalidate)
    begin
      for (int line = 0; line < `IC_LINES; line++)
        lineValid[line] = 1'b0;
    end
    if (!reset)
    begin
      // Completed store
      if (memWrite && !dStall)
        storeWrite();
      // Completed load
      if (memRead && !dStall)
      begin
        expData = expectRead(dataAddr, byteMask);
        checkCount++;
        if (readData !== expData)
        begin
          errCount++;
          $display("MISMATCH time=%0t signal=readData expected=%h actual=%h",
                   $time, expData, readData);
        end
      end
      // Completed fetch
      if (fetchCheck && !iStall)
      begin
        expectFetch(pc, expInstr);
        checkCount++;
        if (instr !== expInstr)
        begin
          errCount++;
          $display("MISMATCH time=%0t signal=instr expected=%h actual=%h",
                   $time, expInstr, instr);
        end
      end
    end
  end

endmodule

// File: bench/clockGen.sv
// Testbench clock with a 20 ns period and a synchronous reset held for 4 cycles
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);

  localparam real HalfPeriod  = 10.0;
  localparam int  ResetCycles = 4;

  initial
  begin
    clk = 1'b0;
    forever
      #(HalfPeriod) clk = ~clk;
  end

  // Released just after the fourth rising edge
  initial
  begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// File: rtl/memSystem.sv
// Memory system top with instruction cache and data port sharing one bus memory
`timescale 1ns/1ps

module memSystem (
  input  logic                clk,
  input  logic                reset,
  input  memSysPkg::addrT     pc,
  input  logic                icEnable,
  input  logic                icInvalidate,
  output memSysPkg::wordT     instr,
  output logic                iStall,
  input  memSysPkg::addrT     dataAddr,
  input  memSysPkg::wordT     writeData,
  input  logic                memRead,
  input  logic                memWrite,
  input  memSysPkg::byteMaskT byteMask,
  output memSysPkg::wordT     readData,
  output logic                dStall
);

  // Masters to arbiter
  memSysPkg::busReqT icReq;
  memSysPkg::busReqT dpReq;
  memSysPkg::busRspT icRsp;
  memSysPkg::busRspT dpRsp;

  // Arbiter to memory
  memSysPkg::busReqT memReq;
  memSysPkg::busRspT memRsp;

  instrCache instrCache0 (
    .clk       (clk         ),
    .reset     (reset       ),
    .enable    (icEnable    ),
    .invalidate(icInvalidate),
    .pc        (pc          ),
    .instr     (instr       ),
    .iStall    (iStall      ),
    .busReq    (icReq       ),
    .busRsp    (icRsp       )
  );

  dataPort dataPort0 (
    .clk      (clk      ),
    .reset    (reset    ),
    .addr     (dataAddr ),
    .writeData(writeData),
    .memRead  (memRead  ),
    .memWrite (memWrite ),
    .byteMask (byteMask ),
    .readData (readData ),
    .dStall   (dStall   ),
    .busReq   (dpReq    ),
    .busRsp   (dpRsp    )
  );

  busArbiter busArbiter0 (
    .clk   (clk   ),
    .reset (reset ),
    .icReq (icReq ),
    .dpReq (dpReq ),
    .icRsp (icRsp ),
    .dpRsp (dpRsp ),
    .memReq(memReq),
    .memRsp(memRsp)
  );

  busMemory busMemory0 (
    .clk  (clk   ),
    .reset(reset ),
    .req  (memReq),
    .rsp  (memRsp)
  );

endmodule

// File: instrCache/instrCache.sv
// Instruction cache with direct-mapped lines refilled over the shared bus
`timescale 1ns/1ps
`include "memSystem_settings.svh"

module instrCache (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  input  logic              invalidate,
  input  memSysPkg::addrT   pc,
  output memSysPkg::wordT   instr,
  output logic              iStall,
  output memSysPkg::busReqT busReq,
  input  memSysPkg::busRspT busRsp
);

  localparam int OffsetBits = $clog2(`IC_BLOCK_WORDS);
  localparam int IndexBits  = $clog2(`IC_LINES);
  localparam int TagBits    = 30 - OffsetBits - IndexBits;
  localparam int LastWord   = `IC_BLOCK_WORDS - 1;

  // Fetch address split into word offset, line index and tag
  logic [OffsetBits-1:0] offset;
  logic [IndexBits-1:0]  index;
  logic [TagBits-1:0]    tag;

  // Line state
  logic [`IC_LINES-1:0]  valid;
  logic [TagBits-1:0]    tagArr  [`IC_LINES];
  memSysPkg::wordT       dataArr [`IC_LINES][`IC_BLOCK_WORDS];

  logic                  hit;
  logic [OffsetBits-1:0] refillCnt;
  logic                  refillWord;
  logic                  lastWord;

  assign offset = pc[2 +: OffsetBits];
  assign index  = pc[2 + OffsetBits +: IndexBits];
  assign tag    = pc[31 -: TagBits];

  assign hit = valid[index] && (tagArr[index] == tag);

  // A refill word lands on each ready during a miss
  assign refillWord = enable && !hit && busRsp.ready;
  assign lastWord   = (refillCnt == LastWord[OffsetBits-1:0]);

  // Valid bits and refill position
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid     <= '0;
      refillCnt <= '0;
    end
    else if (invalidate)
    begin
      // Flash clear, any refill starts over
      valid     <= '0;
      refillCnt <= '0;
    end
    else if (!enable)
    begin
      refillCnt <= '0;
    end
    else if (refillWord)
    begin
      // Line stays invalid until its last word is in
      valid[index] <= lastWord;
      // Wraps back to zero after the last word
      refillCnt    <= refillCnt + 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk)
  begin
    if (refillWord)
    begin
      dataArr[index][refillCnt] <= busRsp.rData;
      tagArr[index]             <= tag;
    end
  end

  // Bus request
  always_comb
  begin
    busReq       = '0;
    busReq.size  = memSysPkg::sizeWord;
    busReq.lanes = 4'b1111;
    if (enable)
    begin
      // Line walk, lowest word first
      busReq.req  = !hit;
      busReq.addr = {pc[31:2 + OffsetBits], refillCnt, 2'b00};
    end
    else
    begin
      // Bypass fetches one word per transfer
      busReq.req  = 1'b1;
      busReq.addr = {pc[31:2], 2'b00};
    end
  end

  // Hit data or bypassed bus word
  assign instr  = enable ? dataArr[index][offset] : busRsp.rData;
  assign iStall = enable ? !hit : !busRsp.ready;

  // Refill counter only advances in enabled cycles
  refillNeedsEnable: assert property (@(posedge clk) disable iff (reset)
    ($changed(refillCnt) && (refillCnt != '0)) |-> $past(enable))
    else $error("instrCache: refill counter advanced while disabled");

endmodule

// File: rtl/dataPort.sv
// Data port for uncached loads and stores with byte-lane bus transfers
`timescale 1ns/1ps

module dataPort (
  input  logic                clk,
  input  logic                reset,
  input  memSysPkg::addrT     addr,
  input  memSysPkg::wordT     writeData,
  input  logic                memRead,
  input  logic                memWrite,
  input  memSysPkg::byteMaskT byteMask,
  output memSysPkg::wordT     readData,
  output logic                dStall,
  output memSysPkg::busReqT   busReq,
  input  memSysPkg::busRspT   busRsp
);

  logic             access;
  logic             pending;
  logic [1:0]       lowLane;
  logic [1:0]       laneSel;
  logic [4:0]       shiftBits;
  memSysPkg::hSizeT size;
  memSysPkg::wordT  laneBits;

  assign access = memRead || memWrite;

  // Lowest enabled lane
  always_comb
  begin
    if (byteMask[0])
      lowLane = 2'd0;
    else if (byteMask[1])
      lowLane = 2'd1;
    else if (byteMask[2])
      lowLane = 2'd2;
    else if (byteMask[3])
      lowLane = 2'd3;
    else
      lowLane = 2'd0;
  end

  // Size from lane count
  always_comb
  begin
    case ($countones(byteMask))
      1:
        size = memSysPkg::sizeByte;
      2:
        size = memSysPkg::sizeHalf;
      default:
        size = memSysPkg::sizeWord;
    endcase
  end

  // Word transfers stay aligned to lane 0
  assign laneSel   = (size == memSysPkg::sizeWord) ? 2'd0 : lowLane;
  assign shiftBits = {laneSel, 3'b000};
  assign laneBits  = {{8{byteMask[3]}}, {8{byteMask[2]}}, {8{byteMask[1]}}, {8{byteMask[0]}}};

  // Core data sits at bit 0, bus data sits in its lanes
  always_comb
  begin
    busReq       = '0;
    busReq.req   = access;
    busReq.write = memWrite;
    busReq.addr  = {addr[31:2], laneSel};
    busReq.size  = size;
    busReq.lanes = byteMask;
    busReq.wData = writeData << shiftBits;
  end

  // Selected lanes, zero-extended
  assign readData = (busRsp.rData & laneBits) >> shiftBits;
  assign dStall   = access && !busRsp.ready;

  // Stalled last cycle
  always_ff @(posedge clk)
  begin
    if (reset)
      pending <= 1'b0;
    else
      pending <= dStall;
  end

  noReadWrite: assert property (@(posedge clk) disable iff (reset)
    !(memRead && memWrite))
    else $error("dataPort: read and write requested together");

  // Core holds its access while stalled
  coreHolds: assert property (@(posedge clk) disable iff (reset)
    pending |-> access && $stable(addr) && $stable(byteMask)
                && (!memWrite || $stable(writeData)))
    else $error("dataPort: access changed during stall");

endmodule

// File: rtl/busArbiter.sv
// Bus arbiter granting the memory to the data port or the instruction cache
`timescale 1ns/1ps

module busArbiter (
  input  logic              clk,
  input  logic              reset,
  input  memSysPkg::busReqT icReq,
  input  memSysPkg::busReqT dpReq,
  output memSysPkg::busRspT icRsp,
  output memSysPkg::busRspT dpRsp,
  output memSysPkg::busReqT memReq,
  input  memSysPkg::busRspT memRsp
);

  memSysPkg::arbStateT state;
  memSysPkg::arbStateT nextState;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= memSysPkg::arbIdle;
    else
      state <= nextState;
  end

  // Grant selection
  always_comb
  begin
    nextState = state;
    case (state)
      memSysPkg::arbIdle:
      begin
        // Data side first
        if (dpReq.req)
          nextState = memSysPkg::arbData;
        else if (icReq.req)
          nextState = memSysPkg::arbInstr;
      end
      memSysPkg::arbData, memSysPkg::arbInstr:
      begin
        // Grant ends with the memory ready pulse
        if (memRsp.ready)
          nextState = memSysPkg::arbIdle;
      end
      default:
        nextState = memSysPkg::arbIdle;
    endcase
  end

  // Forward the granted request, nothing while idle
  always_comb
  begin
    case (state)
      memSysPkg::arbData:
        memReq = dpReq;
      memSysPkg::arbInstr:
        memReq = icReq;
      default:
        memReq = '0;
    endcase
  end

  // Read data goes to both sides, ready only to the granted one
  always_comb
  begin
    icRsp       = memRsp;
    dpRsp       = memRsp;
    icRsp.ready = memRsp.ready && (state == memSysPkg::arbInstr);
    dpRsp.ready = memRsp.ready && (state == memSysPkg::arbData);
  end

  oneReadyOnly: assert property (@(posedge clk) disable iff (reset)
    !(icRsp.ready && dpRsp.ready))
    else $error("busArbiter: ready routed to both sides");

  // Granted master keeps requesting until its ready
  grantHeld: assert property (@(posedge clk) disable iff (reset)
    (state == memSysPkg::arbData) |-> dpReq.req)
    else $error("busArbiter: data request dropped before ready");

endmodule

// File: rtl/busMemory.sv
// Bus memory with byte-lane writes and a fixed wait-state ready pulse
`timescale 1ns/1ps
`include "memSystem_settings.svh"

module busMemory (
  input  logic              clk,
  input  logic              reset,
  input  memSysPkg::busReqT req,
  output memSysPkg::busRspT rsp
);

  localparam int WaitBits = $clog2(`MEM_WAIT + 2);

  memSysPkg::wordT           mem [`MEM_WORDS];
  logic [`MEM_ADDR_BITS-1:0] wordIdx;
  logic                      busy;
  logic [WaitBits-1:0]       waitCnt;
  logic                      ready;

  assign wordIdx = req.addr[`MEM_ADDR_BITS+1:2];

  // Ready after MEM_WAIT busy cycles
  assign ready = busy && (waitCnt == WaitBits'(`MEM_WAIT));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy    <= 1'b0;
      waitCnt <= '0;
    end
    else if (!busy)
    begin
      // Accept a new transfer
      busy    <= req.req;
      waitCnt <= '0;
    end
    else if (ready)
    begin
      busy <= 1'b0;
    end
    else
    begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  // Store on the ready edge, enabled lanes only
  always_ff @(posedge clk)
  begin
    if (ready && req.write)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        if (req.lanes[lane])
          mem[wordIdx][8*lane +: 8] <= req.wData[8*lane +: 8];
      end
    end
  end

  always_comb
  begin
    rsp.ready = ready;
    rsp.rData = mem[wordIdx];
  end

  // Master holds the address for the whole transfer
  addrStable: assert property (@(posedge clk) disable iff (reset)
    busy |-> $stable(req.addr))
    else $error("busMemory: address changed during transfer");

endmodule

// File: common/memSysPkg.sv
// Memory system package with bus types, transfer sizes and arbiter states
package memSysPkg;

  // Byte address
  typedef logic [31:0] addrT;

  // Data word
  typedef logic [31:0] wordT;

  // One enable per byte lane
  typedef logic [3:0] byteMaskT;

  // Transfer size as on an AHB bus
  typedef logic [2:0] hSizeT;

  // HSIZE codes
  localparam hSizeT sizeByte = 3'd0;
  localparam hSizeT sizeHalf = 3'd1;
  localparam hSizeT sizeWord = 3'd2;

  // Request from a bus master
  // Level held until ready, lanes select bytes of the word
  typedef struct packed {
    logic     req;
    logic     write;
    addrT     addr;
    hSizeT    size;
    byteMaskT lanes;
    wordT     wData;
  } busReqT;

  // Response from the memory
  // Ready is a single-cycle pulse
  typedef struct packed {
    logic ready;
    wordT rData;
  } busRspT;

  // Bus grant states
  typedef enum logic [1:0] {
    arbIdle,
    arbData,
    arbInstr
  } arbStateT;

endpackage

// File: common/memSystem_settings.svh
// Memory system sizes for cache geometry, memory depth and bus wait states
`ifndef MEMSYSTEM_SETTINGS_SVH
`define MEMSYSTEM_SETTINGS_SVH

// Instruction cache lines
`define IC_LINES        16

// Words in one cache line
`define IC_BLOCK_WORDS  4

// Bus memory depth in words
`define MEM_WORDS       1024

// Word address width for MEM_WORDS
`define MEM_ADDR_BITS   10

// Cycles between accepting a request and the ready pulse
`define MEM_WAIT        2

`endif
